//--- hdl/motor_pkg.sv
package motor_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int COUNT_W = 32;   // encoder position
	localparam int SPEED_W = 16;   // counts per tick
	localparam int DUTY_W  = 8;    // pwm resolution
	localparam int INTEG_W = 24;   // pi integrator
	localparam int IDX_W   = 3;    // up to 8 motors addressable

	typedef logic signed [COUNT_W-1:0] count_t;
	typedef logic signed [SPEED_W-1:0] speed_t;
	typedef logic signed [INTEG_W-1:0] integ_t;
	typedef logic        [DUTY_W-1:0]  duty_t;
	typedef logic        [IDX_W-1:0]   motor_idx_t;

	// encoder line filter
	typedef enum logic {
		DEB_STABLE   = 1'b0,
		DEB_SETTLING = 1'b1
	} deb_state_e;

	// host setpoint port, four-phase req/ack
	typedef enum logic [1:0] {
		HS_IDLE    = 2'd0,
		HS_ACKED   = 2'd1,
		HS_RELEASE = 2'd2
	} hs_state_e;

	// ==============================
	// defaults and loop constants
	// ==============================
	localparam int               DEF_NUM_MOTORS      = 6;
	localparam int               DEF_TICK_CYCLES     = 250000;    // 5 ms at 50 MHz
	localparam int               DEF_DEBOUNCE_CYCLES = 16;
	localparam logic [5:0]       DEF_MIRROR_MASK     = 6'b111000; // right side, motors 3..5
	localparam int               KP_SHIFT            = 2;
	localparam int               KI_SHIFT            = 4;
	localparam int               DUTY_MAX            = 255;

endpackage

//--- hdl/quad_decoder.sv
`timescale 1ns/1ps

module quad_decoder #(
	parameter int DEBOUNCE_CYCLES = motor_pkg::DEF_DEBOUNCE_CYCLES
) (
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  logic              enc_a,
	input  logic              enc_b,
	output motor_pkg::count_t count
);
	import motor_pkg::*;

	localparam int DCNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	// bit 1 = line a, bit 0 = line b
	logic [1:0]        sync_q1;
	logic [1:0]        sync_q2;
	logic [1:0]        filt;        // debounced pair, resets low
	logic [1:0]        filt_prev;   // pair seen by the decoder one cycle ago
	deb_state_e        deb_state [2];
	logic [DCNT_W-1:0] deb_cnt [2];
	logic              step_up;
	logic              step_dn;

	// ==============================
	// two flop synchronizer
	// ==============================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end
		else
		begin
			sync_q1 <= {enc_a, enc_b};
			sync_q2 <= sync_q1;
		end
	end

	// per line stability filter
	// new level must be seen DEBOUNCE_CYCLES samples in a row
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			filt <= '0;
			for (int i = 0; i < 2; i++)
			begin
				deb_state[i] <= DEB_STABLE;
				deb_cnt[i]   <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				case (deb_state[i])
					DEB_STABLE:
					begin
						if (sync_q2[i] != filt[i])
						begin
							deb_state[i] <= DEB_SETTLING;
							deb_cnt[i]   <= DCNT_W'(1);   // first sample of new level
						end
					end
					default:
					begin
						if (sync_q2[i] == filt[i])
							deb_state[i] <= DEB_STABLE;  // glitch, back to old level
						else if (deb_cnt[i] >= DCNT_W'(DEBOUNCE_CYCLES - 1))
						begin
							filt[i]      <= sync_q2[i];
							deb_state[i] <= DEB_STABLE;
						end
						else
							deb_cnt[i] <= deb_cnt[i] + 1'b1;
					end
				endcase
			end
		end
	end

	// ==============================
	// 4x decode
	// ==============================
	// a leading b: 00 -> 10 -> 11 -> 01 -> 00 counts up
	always_comb
	begin
		step_up = 1'b0;
		step_dn = 1'b0;
		case ({filt_prev, filt})
			4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_up = 1'b1;
			4'b10_00, 4'b11_10, 4'b01_11, 4'b00_01: step_dn = 1'b1;
			default: ;  // no move or double-bit jump
		endcase
	end

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			filt_prev <= '0;
			count     <= '0;
		end
		else
		begin
			filt_prev <= filt;
			if (step_up)
				count <= count + 1'b1;
			else if (step_dn)
				count <= count - 1'b1;
		end
	end

	// filtered line moves only after DEBOUNCE_CYCLES steady samples
	for (genvar i = 0; i < 2; i++)
	begin : g_line_chk
		for (genvar j = 1; j <= DEBOUNCE_CYCLES; j++)
		begin : g_hist
			assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
				$changed(filt[i]) |-> ($past(sync_q2[i], j) == filt[i]));
		end
	end

endmodule

//--- hdl/speed_meter.sv
`timescale 1ns/1ps

module speed_meter #(
	parameter bit MIRROR = 1'b0
) (
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  logic              tick,
	input  motor_pkg::count_t count,
	output motor_pkg::speed_t speed
);
	import motor_pkg::*;

	// speed_t range held in count width for the compare
	localparam count_t SPEED_MAX = count_t'(2 ** (SPEED_W - 1) - 1);
	localparam count_t SPEED_MIN = -count_t'(2 ** (SPEED_W - 1));

	count_t last_count;   // count stored on previous tick
	count_t delta;        // counts this window, sign already mirrored

	// mirrored motors face the other way on the chassis
	always_comb
	begin
		delta = MIRROR ? (last_count - count) : (count - last_count);
	end

	// ==============================
	// window sample
	// ==============================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			last_count <= '0;
			speed      <= '0;
		end
		else if (tick)
		begin
			last_count <= count;
			// clip to speed_t
			if (delta > SPEED_MAX)
				speed <= speed_t'(SPEED_MAX);
			else if (delta < SPEED_MIN)
				speed <= speed_t'(SPEED_MIN);
			else
				speed <= speed_t'(delta);
		end
	end

endmodule

//--- hdl/speed_regulator.sv
`timescale 1ns/1ps

module speed_regulator (
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  logic              tick,
	input  motor_pkg::speed_t setpoint,
	input  motor_pkg::speed_t speed,
	output motor_pkg::duty_t  duty,
	output logic              dir_a,
	output logic              dir_b
);
	import motor_pkg::*;

	localparam integ_t INTEG_MAX = integ_t'({1'b0, {(INTEG_W - 1){1'b1}}});
	localparam integ_t INTEG_MIN = integ_t'({1'b1, {(INTEG_W - 1){1'b0}}});

	logic                    tick_d;      // speed is fresh one cycle after tick
	integ_t                  integ;
	logic signed [SPEED_W:0] err;         // one extra bit, no overflow
	logic signed [INTEG_W:0] integ_sum;
	integ_t                  integ_next;
	logic signed [INTEG_W:0] cmd;
	logic [INTEG_W:0]        mag;
	duty_t                   duty_next;

	// ==============================
	// PI math
	// ==============================
	always_comb
	begin
		err = {setpoint[SPEED_W-1], setpoint} - {speed[SPEED_W-1], speed};

		// integrator with clip at both rails
		integ_sum = {integ[INTEG_W-1], integ} + {{(INTEG_W - SPEED_W){err[SPEED_W]}}, err};
		if (integ_sum[INTEG_W] != integ_sum[INTEG_W-1])
			integ_next = integ_sum[INTEG_W] ? INTEG_MIN : INTEG_MAX;
		else
			integ_next = integ_sum[INTEG_W-1:0];

		// arithmetic shifts, gains are powers of two
		cmd = (err >>> KP_SHIFT) + (integ_next >>> KI_SHIFT);

		mag = cmd[INTEG_W] ? -cmd : cmd;
		if (mag > (INTEG_W + 1)'(DUTY_MAX))
			duty_next = duty_t'(DUTY_MAX);
		else
			duty_next = mag[DUTY_W-1:0];
	end

	// update once per control tick
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			tick_d <= 1'b0;
			integ  <= '0;
			duty   <= '0;
			dir_a  <= 1'b0;
			dir_b  <= 1'b0;
		end
		else
		begin
			tick_d <= tick;
			if (tick_d)
			begin
				integ <= integ_next;
				duty  <= duty_next;
				dir_a <= !cmd[INTEG_W] && (cmd != '0);   // forward
				dir_b <= cmd[INTEG_W];                    // reverse
			end
		end
	end

	// bridge never shorted, and a direction is set exactly when the motor is driven
	assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		!(dir_a && dir_b) && ((dir_a || dir_b) == (duty != '0)));

endmodule

//--- hdl/pwm_generator.sv
`timescale 1ns/1ps

module pwm_generator (
	input  logic             fpga_clk_50,
	input  logic             hps_fpga_reset_n,
	input  motor_pkg::duty_t duty,
	output logic             pwm
);
	import motor_pkg::*;

	duty_t cnt;      // free running, 256 cycle period
	duty_t shadow;   // duty for the current period

	// ==============================
	// period counter
	// ==============================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			cnt    <= '0;
			shadow <= '0;
		end
		else
		begin
			cnt <= cnt + 1'b1;   // 255 wraps to 0
			// new duty only at the wrap, no short pulses mid period
			if (cnt == '1)
				shadow <= duty;
		end
	end

	// high for exactly shadow cycles out of 256
	assign pwm = (cnt < shadow);

endmodule

//--- hdl/setpoint_scheduler.sv
`timescale 1ns/1ps

module setpoint_scheduler #(
	parameter int NUM_MOTORS  = motor_pkg::DEF_NUM_MOTORS,
	parameter int TICK_CYCLES = motor_pkg::DEF_TICK_CYCLES
) (
	input  logic                  fpga_clk_50,
	input  logic                  hps_fpga_reset_n,
	input  logic                  sp_req,
	input  motor_pkg::motor_idx_t sp_motor,
	input  motor_pkg::speed_t     sp_value,
	output logic                  sp_ack,
	output logic                  tick,
	output motor_pkg::speed_t     setpoint [NUM_MOTORS]
);
	import motor_pkg::*;

	localparam int TCNT_W = $clog2(TICK_CYCLES + 1);

	logic [TCNT_W-1:0] tick_cnt;
	hs_state_e         hs_state;
	speed_t            pending [NUM_MOTORS];   // written by host, used from next tick
	logic              wr_en;

	// ==============================
	// control tick
	// ==============================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end
		else if (tick_cnt == TCNT_W'(TICK_CYCLES - 1))
		begin
			tick_cnt <= '0;
			tick     <= 1'b1;   // single cycle pulse
		end
		else
		begin
			tick_cnt <= tick_cnt + 1'b1;
			tick     <= 1'b0;
		end
	end

	// ==============================
	// host handshake
	// ==============================
	// out of range motor index is acked but dropped
	assign wr_en = (hs_state == HS_IDLE) && sp_req && (int'(sp_motor) < NUM_MOTORS);

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			hs_state <= HS_IDLE;
			sp_ack   <= 1'b0;
		end
		else
		begin
			case (hs_state)
				HS_IDLE:
				begin
					if (sp_req)
					begin
						hs_state <= HS_ACKED;
						sp_ack   <= 1'b1;
					end
				end
				HS_ACKED:
				begin
					if (!sp_req)
					begin
						hs_state <= HS_RELEASE;
						sp_ack   <= 1'b0;   // host may start again once it sees this
					end
				end
				default:
					hs_state <= HS_IDLE;
			endcase
		end
	end

	// pending slots and active vector
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			for (int i = 0; i < NUM_MOTORS; i++)
			begin
				pending[i]  <= '0;
				setpoint[i] <= '0;
			end
		end
		else
		begin
			if (wr_en)
				pending[sp_motor] <= sp_value;
			if (tick)
				setpoint <= pending;   // all motors switch together
		end
	end

	// ack only ever answers a request the host is holding
	assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		$rose(sp_ack) |-> $past(sp_req));

endmodule

//--- hdl/motor_ctrl_top.sv
`timescale 1ns/1ps

module motor_ctrl_top #(
	parameter int                    NUM_MOTORS      = motor_pkg::DEF_NUM_MOTORS,
	parameter int                    TICK_CYCLES     = motor_pkg::DEF_TICK_CYCLES,
	parameter int                    DEBOUNCE_CYCLES = motor_pkg::DEF_DEBOUNCE_CYCLES,
	parameter logic [NUM_MOTORS-1:0] MIRROR_MASK     = motor_pkg::DEF_MIRROR_MASK
) (
	input  logic                  fpga_clk_50,
	input  logic                  hps_fpga_reset_n,
	input  logic [NUM_MOTORS-1:0] enc_a,
	input  logic [NUM_MOTORS-1:0] enc_b,
	input  logic                  sp_req,
	input  motor_pkg::motor_idx_t sp_motor,
	input  motor_pkg::speed_t     sp_value,
	output logic                  sp_ack,
	output logic [NUM_MOTORS-1:0] pwm,
	output logic [NUM_MOTORS-1:0] dir_a,
	output logic [NUM_MOTORS-1:0] dir_b,
	output motor_pkg::speed_t     meas_speed [NUM_MOTORS]
);
	import motor_pkg::*;

	logic   tick;                    // control tick, stays inside
	speed_t setpoint [NUM_MOTORS];   // active setpoints
	count_t count    [NUM_MOTORS];
	duty_t  duty     [NUM_MOTORS];

	// ==============================
	// shared tick and host port
	// ==============================
	setpoint_scheduler #(
		.NUM_MOTORS  (NUM_MOTORS),
		.TICK_CYCLES (TICK_CYCLES)
	) u_sched (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.sp_req           (sp_req),
		.sp_motor         (sp_motor),
		.sp_value         (sp_value),
		.sp_ack           (sp_ack),
		.tick             (tick),
		.setpoint         (setpoint)
	);

	// one chain per motor: encoder -> speed -> PI -> pwm
	for (genvar i = 0; i < NUM_MOTORS; i++)
	begin : g_motor
		quad_decoder #(
			.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
		) u_dec (
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.enc_a            (enc_a[i]),
			.enc_b            (enc_b[i]),
			.count            (count[i])
		);

		speed_meter #(
			.MIRROR (MIRROR_MASK[i])   // right side runs mirrored
		) u_meter (
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.tick             (tick),
			.count            (count[i]),
			.speed            (meas_speed[i])
		);

		speed_regulator u_reg (
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.tick             (tick),
			.setpoint         (setpoint[i]),
			.speed            (meas_speed[i]),
			.duty             (duty[i]),
			.dir_a            (dir_a[i]),
			.dir_b            (dir_b[i])
		);

		pwm_generator u_pwm (
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.duty             (duty[i]),
			.pwm              (pwm[i])
		);
	end

endmodule

//--- testbench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic fpga_clk_50,
	output logic hps_fpga_reset_n
);

	initial
	begin
		fpga_clk_50 = 1'b0;
		forever
			#(PERIOD_NS / 2) fpga_clk_50 = ~fpga_clk_50;
	end

	// reset held for RESET_CYCLES rising edges, let go on a falling edge
	initial
	begin
		hps_fpga_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge fpga_clk_50);
		@(negedge fpga_clk_50);
		hps_fpga_reset_n = 1'b1;
	end

endmodule

//--- testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==============================
// speed loop reference model
// ==============================

// counts seen in one window, sign flipped on mirrored motors
function automatic int ref_speed(input int steps, input bit mirror);
	int s;
	s = mirror ? -steps : steps;
	if (s > 32767)
		s = 32767;   // 16 bit signed rails
	else if (s < -32768)
		s = -32768;
	return s;
endfunction

// one PI update per tick, gives the command and the new integrator
function automatic int ref_pi_step(input int sp, input int spd, input int integ_in,
	output int integ_out);
	int err;
	int sum;
	err = sp - spd;
	sum = integ_in + err;
	// integrator clips at the 24 bit rails
	if (sum > 8388607)
		integ_out = 8388607;
	else if (sum < -8388608)
		integ_out = -8388608;
	else
		integ_out = sum;
	return (err >>> motor_pkg::KP_SHIFT) + (integ_out >>> motor_pkg::KI_SHIFT);
endfunction

// command magnitude, at most one full pwm period
function automatic int ref_duty(input int cmd);
	int mag;
	mag = (cmd < 0) ? -cmd : cmd;
	return (mag > motor_pkg::DUTY_MAX) ? motor_pkg::DUTY_MAX : mag;
endfunction

// {dir_a, dir_b}, both low for a zero command
function automatic logic [1:0] ref_dir(input int cmd);
	return {cmd > 0, cmd < 0};
endfunction

`endif

//--- testbench/tb_motor_ctrl.sv
`timescale 1ns/1ps

module tb_motor_ctrl;
	import motor_pkg::*;

	localparam int          NUM_MOTORS  = 6;
	localparam int          TICK_CYCLES = 2000;   // short control tick
	localparam int          DEB_CYCLES  = 4;
	localparam logic [5:0]  MIRROR_MASK = motor_pkg::DEF_MIRROR_MASK;
	localparam logic [31:0] SEED        = 32'h7b03_2854;
	localparam int          STEP_HOLD   = 10;     // cycles per encoder level
	localparam int          BURST_OFF   = 40;     // stimulus start inside a window
	localparam int          PWM_OFF     = 300;    // new duty loaded by then
	localparam int          SAT_OFF     = 700;
	localparam int          HS_TIMEOUT  = 50;
	localparam int          MIN_TICKS   = 12;

	logic                  fpga_clk_50;
	logic                  hps_fpga_reset_n;
	logic [NUM_MOTORS-1:0] enc_a;
	logic [NUM_MOTORS-1:0] enc_b;
	logic                  sp_req;
	motor_idx_t            sp_motor;
	speed_t                sp_value;
	logic                  sp_ack;
	logic [NUM_MOTORS-1:0] pwm;
	logic [NUM_MOTORS-1:0] dir_a;
	logic [NUM_MOTORS-1:0] dir_b;
	speed_t                meas_speed [NUM_MOTORS];

	int cyc           = 0;     // rising edges seen
	int upd_cyc       = 0;     // edge where meas_speed updates
	bit phase_known   = 1'b0;
	int ticks_checked = 0;
	int quad_ph   [NUM_MOTORS];   // gray phase per encoder
	int win_steps [NUM_MOTORS];   // net steps in the open window
	int pend      [NUM_MOTORS];   // model of the pending slots
	int act       [NUM_MOTORS];
	int integ_m   [NUM_MOTORS];

	`include "tb_ref_model.svh"

	clk_gen #(
		.PERIOD_NS    (20),
		.RESET_CYCLES (10)
	) u_clk (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n)
	);

	motor_ctrl_top #(
		.NUM_MOTORS      (NUM_MOTORS),
		.TICK_CYCLES     (TICK_CYCLES),
		.DEBOUNCE_CYCLES (DEB_CYCLES),
		.MIRROR_MASK     (MIRROR_MASK)
	) uut (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a),
		.enc_b            (enc_b),
		.sp_req           (sp_req),
		.sp_motor         (sp_motor),
		.sp_value         (sp_value),
		.sp_ack           (sp_ack),
		.pwm              (pwm),
		.dir_a            (dir_a),
		.dir_b            (dir_b),
		.meas_speed       (meas_speed)
	);

	always @(posedge fpga_clk_50)
		cyc <= cyc + 1;

	// ==============================
	// error and wait helpers
	// ==============================
	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		abort_run();
	endtask

	task automatic check_int(input string what, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_reset_release();
		int t;
		t = 0;
		while (hps_fpga_reset_n !== 1'b1)
		begin
			@(negedge fpga_clk_50);
			t++;
			if (t > 50)
				timed_out("reset release");
		end
	endtask

	// next falling edge at a given offset after the speed update
	task automatic wait_offset(input int off);
		int t;
		t = 0;
		do
		begin
			@(negedge fpga_clk_50);
			t++;
			if (t > 2 * TICK_CYCLES)
				timed_out("window offset");
		end
		while (((cyc - upd_cyc) % TICK_CYCLES) != off);
	endtask

	task automatic idle_window();
		wait_offset(BURST_OFF);
	endtask

	// ==============================
	// encoder and host drivers
	// ==============================
	function automatic logic [1:0] gray_ab(input int ph);
		case (ph)
			0:       return 2'b00;
			1:       return 2'b10;   // a leads
			2:       return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	task automatic set_pins(input int m);
		logic [1:0] ab;
		ab       = gray_ab(quad_ph[m]);
		enc_a[m] = ab[1];
		enc_b[m] = ab[0];
	endtask

	// all motors step together, one level change each per hold
	task automatic quad_burst(input int steps [NUM_MOTORS]);
		int left [NUM_MOTORS];
		int busy;
		int d;
		left = steps;
		busy = 1;
		while (busy != 0)
		begin
			busy = 0;
			for (int m = 0; m < NUM_MOTORS; m++)
			begin
				if (left[m] != 0)
				begin
					d            = (left[m] > 0) ? 1 : -1;
					quad_ph[m]   = (quad_ph[m] + 4 + d) % 4;
					win_steps[m] += d;
					left[m]      -= d;
					busy         = 1;
					set_pins(m);
				end
			end
			repeat (STEP_HOLD) @(negedge fpga_clk_50);
		end
	endtask

	// short pulse on one line, back to the old level
	task automatic glitch_pulse(input int m, input bit on_a, input int width);
		if (on_a)
			enc_a[m] = ~enc_a[m];
		else
			enc_b[m] = ~enc_b[m];
		repeat (width) @(negedge fpga_clk_50);
		if (on_a)
			enc_a[m] = ~enc_a[m];
		else
			enc_b[m] = ~enc_b[m];
		repeat (STEP_HOLD) @(negedge fpga_clk_50);
	endtask

	// four-phase req/ack write
	task automatic sp_write(input int m, input int v);
		int t;
		int hold;
		check_int("sp_ack", sp_ack, 0);   // previous transfer closed
		sp_motor = motor_idx_t'(m);
		sp_value = speed_t'(v);
		sp_req   = 1'b1;
		t = 0;
		while (sp_ack !== 1'b1)
		begin
			@(negedge fpga_clk_50);
			t++;
			if (t > HS_TIMEOUT)
				timed_out("sp_ack to rise");
		end
		if (m < NUM_MOTORS)
			pend[m] = v;   // index out of range is dropped
		hold = $urandom_range(3, 1);
		repeat (hold)
		begin
			@(negedge fpga_clk_50);
			check_int("sp_ack", sp_ack, 1);   // held while req held
		end
		sp_req = 1'b0;
		t = 0;
		while (sp_ack !== 1'b0)
		begin
			@(negedge fpga_clk_50);
			t++;
			if (t > HS_TIMEOUT)
				timed_out("sp_ack to fall");
		end
	endtask

	// high cycles per motor over 256 consecutive cycles
	task automatic count_pwm(output int hi [NUM_MOTORS]);
		for (int m = 0; m < NUM_MOTORS; m++)
			hi[m] = 0;
		repeat (256)
		begin
			@(negedge fpga_clk_50);
			for (int m = 0; m < NUM_MOTORS; m++)
				if (pwm[m])
					hi[m]++;
		end
	endtask

	task automatic check_saturated(input logic [NUM_MOTORS-1:0] exp_a,
		input logic [NUM_MOTORS-1:0] exp_b);
		int hi [NUM_MOTORS];
		wait_offset(SAT_OFF);
		check_int("dir_a", dir_a, exp_a);
		check_int("dir_b", dir_b, exp_b);
		count_pwm(hi);
		for (int m = 0; m < NUM_MOTORS; m++)
			check_int($sformatf("pwm[%0d] high cycles", m), hi[m], DUTY_MAX);
	endtask

	// ==============================
	// stimulus
	// ==============================
	initial
	begin : stimulus
		int t;
		int steps [NUM_MOTORS];

		enc_a    = '0;
		enc_b    = '0;
		sp_req   = 1'b0;
		sp_motor = '0;
		sp_value = '0;
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			quad_ph[m]   = 0;
			win_steps[m] = 0;
			pend[m]      = 0;
			act[m]       = 0;
			integ_m[m]   = 0;
		end
		void'($urandom(SEED));

		wait_reset_release();
		repeat (5) @(negedge fpga_clk_50);
		check_int("pwm", pwm, 0);   // all quiet before the first tick
		check_int("dir_a", dir_a, 0);
		check_int("dir_b", dir_b, 0);
		check_int("sp_ack", sp_ack, 0);
		for (int m = 0; m < NUM_MOTORS; m++)
			check_int($sformatf("meas_speed[%0d]", m), meas_speed[m], 0);

		// one step cannot split over two windows
		quad_ph[0]   = 1;
		win_steps[0] = 1;
		set_pins(0);
		t = 0;
		while (!phase_known)
		begin
			@(negedge fpga_clk_50);
			t++;
			if (t > 3 * TICK_CYCLES)
				timed_out("tick phase");
		end

		// handshake, motors 6 and 7 acked and dropped
		wait_offset(BURST_OFF);
		repeat (8)
			sp_write($urandom_range(7), int'($urandom_range(300)) - 150);

		// forward, idle, reverse, idle
		wait_offset(BURST_OFF);
		for (int m = 0; m < NUM_MOTORS; m++)
			steps[m] = $urandom_range(40, 1);
		quad_burst(steps);
		idle_window();
		wait_offset(BURST_OFF);
		for (int m = 0; m < NUM_MOTORS; m++)
			steps[m] = -int'($urandom_range(40, 1));
		quad_burst(steps);
		idle_window();

		// pulses shorter than the filter
		wait_offset(BURST_OFF);
		repeat (12)
			glitch_pulse($urandom_range(NUM_MOTORS - 1), $urandom_range(1) == 1,
				$urandom_range(DEB_CYCLES - 1, 1));

		// ==============================
		// regulation over several ticks
		// ==============================
		wait_offset(BURST_OFF);
		for (int m = 0; m < NUM_MOTORS; m++)
			sp_write(m, int'($urandom_range(300)) - 150);
		repeat (4)
		begin
			wait_offset(BURST_OFF);
			for (int m = 0; m < NUM_MOTORS; m++)
				steps[m] = int'($urandom_range(60)) - 30;
			quad_burst(steps);
		end

		// saturation both ways, zero speed
		wait_offset(BURST_OFF);
		for (int m = 0; m < NUM_MOTORS; m++)
			sp_write(m, 30000);
		idle_window();
		check_saturated('1, '0);
		for (int m = 0; m < NUM_MOTORS; m++)
			sp_write(m, -30000);
		idle_window();
		check_saturated('0, '1);

		idle_window();
		idle_window();
		if (ticks_checked >= MIN_TICKS)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("only %0d control ticks were checked", ticks_checked);
			abort_run();
		end
	end

	// ==============================
	// compare, once per control tick
	// ==============================
	initial
	begin : compare
		int         t;
		int         spd;
		int         cmd;
		int         integ_nx;
		int         exp_duty [NUM_MOTORS];
		logic [1:0] exp_dir  [NUM_MOTORS];   // {dir_a, dir_b}
		int         hi       [NUM_MOTORS];

		wait_reset_release();
		// first nonzero speed on motor 0 marks the update edge
		t = 0;
		do
		begin
			@(negedge fpga_clk_50);
			t++;
			if (t > 3 * TICK_CYCLES)
				timed_out("first speed update");
		end
		while (meas_speed[0] == 0);
		upd_cyc     = cyc;
		phase_known = 1'b1;

		forever
		begin
			for (int m = 0; m < NUM_MOTORS; m++)
			begin
				spd          = ref_speed(win_steps[m], MIRROR_MASK[m]);
				win_steps[m] = 0;
				check_int($sformatf("meas_speed[%0d]", m), meas_speed[m], spd);
				act[m]       = pend[m];   // pending goes live on the tick
				cmd          = ref_pi_step(act[m], spd, integ_m[m], integ_nx);
				integ_m[m]   = integ_nx;
				exp_duty[m]  = ref_duty(cmd);
				exp_dir[m]   = ref_dir(cmd);
			end
			ticks_checked++;

			repeat (3) @(negedge fpga_clk_50);   // regulator output settled
			for (int m = 0; m < NUM_MOTORS; m++)
			begin
				check_int($sformatf("dir_a[%0d]", m), dir_a[m], exp_dir[m][1]);
				check_int($sformatf("dir_b[%0d]", m), dir_b[m], exp_dir[m][0]);
			end

			wait_offset(PWM_OFF);
			count_pwm(hi);
			for (int m = 0; m < NUM_MOTORS; m++)
				check_int($sformatf("pwm[%0d] high cycles", m), hi[m], exp_duty[m]);

			wait_offset(0);
		end
	end

endmodule

//--- src.f
+incdir+testbench
hdl/motor_pkg.sv
hdl/quad_decoder.sv
hdl/speed_meter.sv
hdl/speed_regulator.sv
hdl/pwm_generator.sv
hdl/setpoint_scheduler.sv
hdl/motor_ctrl_top.sv
testbench/clk_gen.sv
testbench/tb_motor_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the motor control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_motor_ctrl -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_motor_ctrl)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test completed successfully"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
